// File: hdl/mips_pkg.sv
package mips_pkg;

	// major opcodes
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_regimm  = 6'b000001;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_jal     = 6'b000011;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_blez    = 6'b000110;
	localparam logic [5:0] op_bgtz    = 6'b000111;
	localparam logic [5:0] op_addi    = 6'b001000;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_sltiu   = 6'b001011;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;
	localparam logic [5:0] op_cop0    = 6'b010000;
	localparam logic [5:0] op_lb      = 6'b100000;
	localparam logic [5:0] op_lh      = 6'b100001;
	localparam logic [5:0] op_lw      = 6'b100011;
	localparam logic [5:0] op_lbu     = 6'b100100;
	localparam logic [5:0] op_lhu     = 6'b100101;
	localparam logic [5:0] op_sb      = 6'b101000;
	localparam logic [5:0] op_sh      = 6'b101001;
	localparam logic [5:0] op_sw      = 6'b101011;

	// special funct field
	localparam logic [5:0] fn_sll     = 6'b000000;
	localparam logic [5:0] fn_srl     = 6'b000010;
	localparam logic [5:0] fn_sra     = 6'b000011;
	localparam logic [5:0] fn_sllv    = 6'b000100;
	localparam logic [5:0] fn_srlv    = 6'b000110;
	localparam logic [5:0] fn_srav    = 6'b000111;
	localparam logic [5:0] fn_jr      = 6'b001000;
	localparam logic [5:0] fn_jalr    = 6'b001001;
	localparam logic [5:0] fn_syscall = 6'b001100;
	localparam logic [5:0] fn_break   = 6'b001101;
	localparam logic [5:0] fn_mfhi    = 6'b010000;
	localparam logic [5:0] fn_mthi    = 6'b010001;
	localparam logic [5:0] fn_mflo    = 6'b010010;
	localparam logic [5:0] fn_mtlo    = 6'b010011;
	localparam logic [5:0] fn_mult    = 6'b011000;
	localparam logic [5:0] fn_multu   = 6'b011001;
	localparam logic [5:0] fn_div     = 6'b011010;
	localparam logic [5:0] fn_divu    = 6'b011011;
	localparam logic [5:0] fn_add     = 6'b100000;
	localparam logic [5:0] fn_addu    = 6'b100001;
	localparam logic [5:0] fn_sub     = 6'b100010;
	localparam logic [5:0] fn_subu    = 6'b100011;
	localparam logic [5:0] fn_and     = 6'b100100;
	localparam logic [5:0] fn_or      = 6'b100101;
	localparam logic [5:0] fn_xor     = 6'b100110;
	localparam logic [5:0] fn_nor     = 6'b100111;
	localparam logic [5:0] fn_slt     = 6'b101010;
	localparam logic [5:0] fn_sltu    = 6'b101011;

	// regimm rt field
	localparam logic [4:0] rt_bltz    = 5'b00000;
	localparam logic [4:0] rt_bgez    = 5'b00001;
	localparam logic [4:0] rt_bltzal  = 5'b10000;
	localparam logic [4:0] rt_bgezal  = 5'b10001;

	// cop0 rs field
	localparam logic [4:0] rs_mfc0    = 5'b00000;
	localparam logic [4:0] rs_mtc0    = 5'b00100;

	localparam logic [31:0] eret_word = 32'h4200_0018;

	typedef enum logic [1:0] {dst_rt = 2'b00, dst_rd = 2'b01, dst_ra = 2'b10} reg_dst_e;

	typedef enum logic [1:0] {wb_alu = 2'b00, wb_mem = 2'b01, wb_cp0 = 2'b10} wb_src_e;

	typedef enum logic [3:0] {
		alu_add, alu_addu, alu_sub, alu_subu,
		alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra,
		alu_lui, alu_none
	} alu_op_e;

	// field order matches the 15-bit control literals, msb first
	typedef struct packed {
		logic     reg_write;
		reg_dst_e reg_dst;
		logic     alu_src_pc;
		logic     alu_src_imm;
		wb_src_e  wb_src;
		logic     hilo_read;
		logic     hilo_write;
		logic     branch;
		logic     unsign_ext;
		logic     jump;
		logic     mem_load;
		logic     cp0_write;
		logic     cp0_read;
	} ctrl_t;

	typedef struct packed {
		logic ri;
		logic syscall;
		logic brk;
		logic eret;
	} exc_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] instr;
	} fetch_t;

	typedef struct packed {
		logic [31:0] pc;
		ctrl_t       ctrl;
		alu_op_e     alu_op;
		exc_t        exc;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [31:0] imm_ext;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dest;
		logic [4:0]  shamt;
	} decode_t;

endpackage

// File: hdl/main_decoder.sv
`timescale 1ns/1ps

module main_decoder import mips_pkg::*; (
	input  logic [31:0] instr,
	input  logic        flush_except,
	output ctrl_t       ctrl,
	output exc_t        exc
);

	logic [5:0] opcode;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [5:0] funct;
	logic       is_eret;

	assign opcode  = instr[31:26];
	assign rs      = instr[25:21];
	assign rt      = instr[20:16];
	assign funct   = instr[5:0];
	assign is_eret = (instr == eret_word);

	// trap flags are masked while an earlier exception is flushing
	assign exc.syscall = !flush_except && (opcode == op_special) && (funct == fn_syscall);
	assign exc.brk     = !flush_except && (opcode == op_special) && (funct == fn_break);
	assign exc.eret    = is_eret;

	// literal layout: wr_dst_pc_imm_wb_hr_hw_br_ue_j_ld_c0w_c0r
	always_comb begin
		exc.ri = 1'b0;
		ctrl   = ctrl_t'(15'b0_00_0_0_00_0_0_0_0_0_0_0_0);
		case (opcode)
			op_special: begin
				case (funct)
					fn_mthi, fn_mtlo:
						ctrl = ctrl_t'(15'b0_00_0_0_00_1_1_0_0_0_0_0_0);
					fn_mfhi, fn_mflo:
						ctrl = ctrl_t'(15'b1_01_0_0_00_1_0_0_0_0_0_0_0);
					fn_mult, fn_multu, fn_div, fn_divu:
						ctrl = ctrl_t'(15'b1_01_0_0_00_0_1_0_0_0_0_0_0);
					fn_jr: begin
						// rt, rd and sa must all be zero
						if (instr[20:6] != 15'b0)
							exc.ri = 1'b1;
						else
							ctrl = ctrl_t'(15'b0_00_0_0_00_0_0_0_0_1_0_0_0);
					end
					fn_jalr: begin
						if (rt != 5'b0 || instr[10:6] != 5'b0)
							exc.ri = 1'b1;
						else
							ctrl = ctrl_t'(15'b1_01_1_0_00_0_0_0_0_1_0_0_0);
					end
					fn_syscall, fn_break:
						ctrl = ctrl_t'(15'b0_00_0_0_00_0_0_0_0_0_0_0_0);
					// plain alu ops write rd
					default:
						ctrl = ctrl_t'(15'b1_01_0_0_00_0_0_0_0_0_0_0_0);
				endcase
			end
			op_addi, op_addiu, op_slti, op_sltiu:
				ctrl = ctrl_t'(15'b1_00_0_1_00_0_0_0_0_0_0_0_0);
			op_andi, op_ori, op_xori, op_lui:
				ctrl = ctrl_t'(15'b1_00_0_1_00_0_0_0_1_0_0_0_0);
			op_lw, op_lb, op_lbu, op_lh, op_lhu:
				ctrl = ctrl_t'(15'b1_00_0_1_01_0_0_0_0_0_1_0_0);
			op_sw, op_sb, op_sh:
				ctrl = ctrl_t'(15'b0_00_0_1_00_0_0_0_0_0_0_0_0);
			op_beq, op_bne:
				ctrl = ctrl_t'(15'b0_00_0_0_00_0_0_1_0_0_0_0_0);
			op_bgtz, op_blez: begin
				if (rt != 5'b0)
					exc.ri = 1'b1;
				else
					ctrl = ctrl_t'(15'b0_00_0_0_00_0_0_1_0_0_0_0_0);
			end
			op_regimm: begin
				case (rt)
					// link variants write r31 with pc+8
					rt_bltzal, rt_bgezal:
						ctrl = ctrl_t'(15'b1_10_1_0_00_0_0_1_0_0_0_0_0);
					rt_bltz, rt_bgez:
						ctrl = ctrl_t'(15'b0_00_0_0_00_0_0_1_0_0_0_0_0);
					default:
						exc.ri = 1'b1;
				endcase
			end
			op_j:
				ctrl = ctrl_t'(15'b0_00_0_0_00_0_0_0_0_1_0_0_0);
			op_jal:
				ctrl = ctrl_t'(15'b1_10_1_0_00_0_0_0_0_1_0_0_0);
			op_cop0: begin
				case (rs)
					rs_mfc0:
						ctrl = ctrl_t'(15'b1_00_0_0_10_0_0_0_0_0_0_0_1);
					rs_mtc0:
						ctrl = ctrl_t'(15'b0_00_0_0_00_0_0_0_0_0_0_1_0);
					default:
						exc.ri = !is_eret;
				endcase
			end
			default:
				exc.ri = 1'b1;
		endcase
		assert (!(ctrl.branch && ctrl.jump));
	end

endmodule

// File: hdl/alu_decoder.sv
`timescale 1ns/1ps

module alu_decoder import mips_pkg::*; (
	input  logic [31:0] instr,
	output alu_op_e     alu_op
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		alu_op = alu_none;
		case (opcode)
			op_special: begin
				case (funct)
					fn_add:               alu_op = alu_add;
					fn_addu:              alu_op = alu_addu;
					fn_sub:               alu_op = alu_sub;
					fn_subu:              alu_op = alu_subu;
					fn_and:               alu_op = alu_and;
					fn_or:                alu_op = alu_or;
					fn_xor:               alu_op = alu_xor;
					fn_nor:               alu_op = alu_nor;
					fn_slt:               alu_op = alu_slt;
					fn_sltu:              alu_op = alu_sltu;
					// variable shifts share the fixed shift ops
					fn_sll, fn_sllv:      alu_op = alu_sll;
					fn_srl, fn_srlv:      alu_op = alu_srl;
					fn_sra, fn_srav:      alu_op = alu_sra;
					fn_jr, fn_jalr:       alu_op = alu_add;
					default:              alu_op = alu_none;
				endcase
			end
			op_addi:                      alu_op = alu_add;
			op_addiu:                     alu_op = alu_addu;
			op_slti:                      alu_op = alu_slt;
			op_sltiu:                     alu_op = alu_sltu;
			op_andi:                      alu_op = alu_and;
			op_ori:                       alu_op = alu_or;
			op_xori:                      alu_op = alu_xor;
			op_lui:                       alu_op = alu_lui;
			// address and link computations
			op_lw, op_lb, op_lbu, op_lh, op_lhu,
			op_sw, op_sb, op_sh:          alu_op = alu_add;
			op_beq, op_bne, op_blez, op_bgtz,
			op_regimm, op_j, op_jal:      alu_op = alu_add;
			default:                      alu_op = alu_none;
		endcase
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
	parameter int REG_COUNT = 32
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	input  logic [4:0]  raddr_a,
	input  logic [4:0]  raddr_b,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b
);

	localparam int addr_w = $clog2(REG_COUNT);

	logic [31:0] regs [REG_COUNT];

	// r0 and anything past the top entry read as zero
	function automatic logic [31:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0 || int'(addr) >= REG_COUNT)
			return 32'd0;
		if (we && waddr == addr)
			return wdata;
		return regs[addr[addr_w-1:0]];
	endfunction

	// reads follow the write port and the stored entries too
	always_comb begin
		rdata_a = read_port(raddr_a);
		rdata_b = read_port(raddr_b);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= 32'd0;
		end else if (we && waddr != 5'd0 && int'(waddr) < REG_COUNT) begin
			regs[waddr[addr_w-1:0]] <= wdata;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) raddr_a == 5'd0 |-> rdata_a == 32'd0);

endmodule

// File: hdl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	// stall wins over flush, so a held entry stays valid
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_data  <= '0;
		end else if (!stall) begin
			out_valid <= in_valid && !flush;
			out_data  <= in_data;
		end
	end

	assert property (@(posedge clk) !rst_n |=> !out_valid);

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; #(
	parameter int REG_COUNT = 32
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        flush_except,
	input  fetch_t      in_data,
	input  logic        wb_en,
	input  logic [4:0]  wb_addr,
	input  logic [31:0] wb_data,
	output decode_t     out_data
);

	logic [31:0] instr;
	logic [15:0] imm;
	logic [4:0]  rd;

	assign instr = in_data.instr;
	assign imm   = instr[15:0];
	assign rd    = instr[15:11];

	assign out_data.pc    = in_data.pc;
	assign out_data.rs    = instr[25:21];
	assign out_data.rt    = instr[20:16];
	assign out_data.shamt = instr[10:6];

	main_decoder u_main_dec (
		.instr        (instr),
		.flush_except (flush_except),
		.ctrl         (out_data.ctrl),
		.exc          (out_data.exc)
	);

	alu_decoder u_alu_dec (
		.instr  (instr),
		.alu_op (out_data.alu_op)
	);

	reg_file #(.REG_COUNT(REG_COUNT)) u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.we      (wb_en),
		.waddr   (wb_addr),
		.wdata   (wb_data),
		.raddr_a (instr[25:21]),
		.raddr_b (instr[20:16]),
		.rdata_a (out_data.rs_val),
		.rdata_b (out_data.rt_val)
	);

	// link instructions target r31
	always_comb begin
		case (out_data.ctrl.reg_dst)
			dst_rd:  out_data.dest = rd;
			dst_ra:  out_data.dest = 5'd31;
			default: out_data.dest = instr[20:16];
		endcase
	end

	assign out_data.imm_ext = out_data.ctrl.unsign_ext ? {16'd0, imm} : {{16{imm[15]}}, imm};

endmodule

// File: hdl/decode_top.sv
`timescale 1ns/1ps

module decode_top import mips_pkg::*; #(
	parameter int REG_COUNT = 32
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        fetch_valid,
	input  fetch_t      fetch,
	input  logic        stall,
	input  logic        flush,
	input  logic        flush_except,
	input  logic        wb_en,
	input  logic [4:0]  wb_addr,
	input  logic [31:0] wb_data,
	output logic        dec_valid,
	output decode_t     dec
);

	logic    if_valid;
	fetch_t  if_data;
	decode_t id_data;

	// fetch/decode register
	pipe_reg #(.payload_t(fetch_t)) u_if_id (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.flush     (flush),
		.in_valid  (fetch_valid),
		.in_data   (fetch),
		.out_valid (if_valid),
		.out_data  (if_data)
	);

	decode_stage #(.REG_COUNT(REG_COUNT)) u_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.flush_except (flush_except),
		.in_data      (if_data),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.out_data     (id_data)
	);

	// decode/execute register, never flushed from here
	pipe_reg #(.payload_t(decode_t)) u_id_ex (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.flush     (1'b0),
		.in_valid  (if_valid),
		.in_data   (id_data),
		.out_valid (dec_valid),
		.out_data  (dec)
	);

endmodule

// File: tests/tb_decode.sv
`timescale 1ns/1ps

module tb_decode import mips_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic        fetch_valid;
	fetch_t      fetch;
	logic        stall;
	logic        flush;
	logic        flush_except;
	logic        wb_en;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        dec_valid;
	decode_t     dec;

	int          errors;
	int          checks;
	logic [31:0] lfsr_state;
	logic [31:0] pc_next;
	// expected register contents
	logic [31:0] shadow [32];

	decode_top #(.REG_COUNT(32)) dut (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] rand_word();
		logic [31:0] w;
		logic        fb;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			w = {w[30:0], lfsr_state[31]};
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
		end
		return w;
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		return {op_special, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// argument order: write dst pc imm wb hi_rd hi_wr branch uext jump load c0w c0r
	function automatic ctrl_t make_ctrl(input logic wr, input reg_dst_e dst, input logic pc,
			input logic imm, input wb_src_e wb, input logic hr, input logic hw,
			input logic br, input logic ue, input logic jmp, input logic ld,
			input logic c0w, input logic c0r);
		ctrl_t c;
		c.reg_write   = wr;
		c.reg_dst     = dst;
		c.alu_src_pc  = pc;
		c.alu_src_imm = imm;
		c.wb_src      = wb;
		c.hilo_read   = hr;
		c.hilo_write  = hw;
		c.branch      = br;
		c.unsign_ext  = ue;
		c.jump        = jmp;
		c.mem_load    = ld;
		c.cp0_write   = c0w;
		c.cp0_read    = c0r;
		return c;
	endfunction

	function automatic exc_t make_exc(input logic ri, input logic sc, input logic bk,
			input logic er);
		exc_t e;
		e.ri      = ri;
		e.syscall = sc;
		e.brk     = bk;
		e.eret    = er;
		return e;
	endfunction

	task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: ctrl expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_exc(input string name, input exc_t exp, input exc_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: exc expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_alu(input string name, input alu_op_e exp, input alu_op_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: alu_op expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic drive_fetch(input logic [31:0] instr);
		fetch_valid = 1'b1;
		fetch.pc    = pc_next;
		fetch.instr = instr;
		pc_next     = pc_next + 32'd4;
	endtask

	// one fetch, optional writeback while it sits in decode, then wait for dec_valid
	task automatic issue(input logic [31:0] instr, input logic wb_on, input logic [4:0] wb_a,
			input logic [31:0] wb_d, output int edges);
		drive_fetch(instr);
		@(posedge clk);
		#1;
		fetch_valid = 1'b0;
		wb_en       = wb_on;
		wb_addr     = wb_a;
		wb_data     = wb_d;
		edges       = 1;
		while (!dec_valid && edges < 20) begin
			@(posedge clk);
			#1;
			wb_en = 1'b0;
			edges++;
		end
		if (!dec_valid) begin
			errors++;
			$display("timeout: instruction %h never showed dec_valid in 20 cycles", instr);
		end
	endtask

	task automatic run_instr(input string name, input logic [31:0] instr, input ctrl_t exp_ctrl,
			input alu_op_e exp_alu, input exc_t exp_exc);
		int edges;
		issue(instr, 1'b0, 5'd0, 32'd0, edges);
		check_ctrl(name, exp_ctrl, dec.ctrl);
		check_alu(name, exp_alu, dec.alu_op);
		check_exc(name, exp_exc, dec.exc);
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		wb_en   = 1'b1;
		wb_addr = addr;
		wb_data = data;
		@(posedge clk);
		#1;
		wb_en = 1'b0;
		if (addr != 5'd0)
			shadow[addr] = data;
	endtask

	task automatic test_reset();
		int edges;
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			#1;
			check_word("reset_valid", 32'd0, {31'd0, dec_valid});
		end
		check_word("reset_payload", 32'd0, dec.pc);
		issue(enc_r(5'd0, 5'd0, 5'd0, fn_sll), 1'b0, 5'd0, 32'd0, edges);
		check_word("latency", 32'd2, 32'(edges));
	endtask

	task automatic test_ctrl();
		exc_t none;
		none = make_exc(0, 0, 0, 0);
		run_instr("addu", enc_r(5'd1, 5'd2, 5'd3, fn_addu),
			make_ctrl(1, dst_rd, 0, 0, wb_alu, 0, 0, 0, 0, 0, 0, 0, 0), alu_addu, none);
		run_instr("addi", enc_i(op_addi, 5'd1, 5'd2, 16'hfff0),
			make_ctrl(1, dst_rt, 0, 1, wb_alu, 0, 0, 0, 0, 0, 0, 0, 0), alu_add, none);
		check_word("addi_imm", 32'hffff_fff0, dec.imm_ext);
		run_instr("ori", enc_i(op_ori, 5'd1, 5'd2, 16'h8001),
			make_ctrl(1, dst_rt, 0, 1, wb_alu, 0, 0, 0, 1, 0, 0, 0, 0), alu_or, none);
		check_word("ori_imm", 32'h0000_8001, dec.imm_ext);
		run_instr("lw", enc_i(op_lw, 5'd3, 5'd4, 16'h0010),
			make_ctrl(1, dst_rt, 0, 1, wb_mem, 0, 0, 0, 0, 0, 1, 0, 0), alu_add, none);
		run_instr("sw", enc_i(op_sw, 5'd3, 5'd4, 16'h0014),
			make_ctrl(0, dst_rt, 0, 1, wb_alu, 0, 0, 0, 0, 0, 0, 0, 0), alu_add, none);
		run_instr("beq", enc_i(op_beq, 5'd1, 5'd2, 16'h0008),
			make_ctrl(0, dst_rt, 0, 0, wb_alu, 0, 0, 1, 0, 0, 0, 0, 0), alu_add, none);
		run_instr("j", {op_j, 26'h000_0400},
			make_ctrl(0, dst_rt, 0, 0, wb_alu, 0, 0, 0, 0, 1, 0, 0, 0), alu_add, none);
		run_instr("mfhi", enc_r(5'd0, 5'd0, 5'd8, fn_mfhi),
			make_ctrl(1, dst_rd, 0, 0, wb_alu, 1, 0, 0, 0, 0, 0, 0, 0), alu_none, none);
		run_instr("mtc0", {op_cop0, rs_mtc0, 5'd9, 5'd12, 11'd0},
			make_ctrl(0, dst_rt, 0, 0, wb_alu, 0, 0, 0, 0, 0, 0, 1, 0), alu_none, none);
	endtask

	task automatic test_regs();
		int          edges;
		logic [31:0] v;
		for (int r = 1; r <= 5; r++)
			write_reg(5'(r), rand_word());
		write_reg(5'd0, rand_word());
		issue(enc_r(5'd1, 5'd2, 5'd3, fn_addu), 1'b0, 5'd0, 32'd0, edges);
		check_word("read_r1", shadow[1], dec.rs_val);
		check_word("read_r2", shadow[2], dec.rt_val);
		issue(enc_r(5'd3, 5'd4, 5'd3, fn_addu), 1'b0, 5'd0, 32'd0, edges);
		check_word("read_r3", shadow[3], dec.rs_val);
		check_word("read_r4", shadow[4], dec.rt_val);
		issue(enc_r(5'd0, 5'd5, 5'd3, fn_addu), 1'b0, 5'd0, 32'd0, edges);
		check_word("read_r0", 32'd0, dec.rs_val);
		check_word("read_r5", shadow[5], dec.rt_val);
		// write in the same cycle as the read
		v = rand_word();
		issue(enc_r(5'd6, 5'd6, 5'd3, fn_addu), 1'b1, 5'd6, v, edges);
		shadow[6] = v;
		check_word("forward_rs", v, dec.rs_val);
		check_word("forward_rt", v, dec.rt_val);
		issue(enc_r(5'd6, 5'd1, 5'd3, fn_addu), 1'b0, 5'd0, 32'd0, edges);
		check_word("read_r6", shadow[6], dec.rs_val);
	endtask

	task automatic test_exceptions();
		ctrl_t zero;
		zero = '0;
		run_instr("jr_reserved", enc_r(5'd4, 5'd0, 5'd3, fn_jr), zero, alu_add,
			make_exc(1, 0, 0, 0));
		run_instr("bad_opcode", enc_i(6'b111111, 5'd1, 5'd2, 16'h0), zero, alu_none,
			make_exc(1, 0, 0, 0));
		run_instr("bad_regimm", enc_i(op_regimm, 5'd1, 5'b00111, 16'h4), zero, alu_add,
			make_exc(1, 0, 0, 0));
		run_instr("eret", eret_word, zero, alu_none, make_exc(0, 0, 0, 1));
		run_instr("syscall", enc_r(5'd0, 5'd0, 5'd0, fn_syscall), zero, alu_none,
			make_exc(0, 1, 0, 0));
		run_instr("break", enc_r(5'd0, 5'd0, 5'd0, fn_break), zero, alu_none,
			make_exc(0, 0, 1, 0));
		flush_except = 1'b1;
		run_instr("syscall_flushed", enc_r(5'd0, 5'd0, 5'd0, fn_syscall), zero, alu_none,
			make_exc(0, 0, 0, 0));
		run_instr("break_flushed", enc_r(5'd0, 5'd0, 5'd0, fn_break), zero, alu_none,
			make_exc(0, 0, 0, 0));
		flush_except = 1'b0;
	endtask

	task automatic test_dest();
		int edges;
		issue({op_jal, 26'h000_0100}, 1'b0, 5'd0, 32'd0, edges);
		check_word("jal_dest", 32'd31, {27'd0, dec.dest});
		issue(enc_i(op_regimm, 5'd2, rt_bltzal, 16'h0004), 1'b0, 5'd0, 32'd0, edges);
		check_word("bltzal_dest", 32'd31, {27'd0, dec.dest});
		issue(enc_r(5'd1, 5'd2, 5'd9, fn_sub), 1'b0, 5'd0, 32'd0, edges);
		check_word("rtype_dest", 32'd9, {27'd0, dec.dest});
		check_word("rtype_rs", 32'd1, {27'd0, dec.rs});
		check_word("rtype_rt", 32'd2, {27'd0, dec.rt});
		issue(enc_i(op_addiu, 5'd1, 5'd12, 16'h0020), 1'b0, 5'd0, 32'd0, edges);
		check_word("itype_dest", 32'd12, {27'd0, dec.dest});
		// shift amount sits in bits 10:6
		issue({op_special, 5'd0, 5'd2, 5'd3, 5'd7, fn_sra}, 1'b0, 5'd0, 32'd0, edges);
		check_word("sra_shamt", 32'd7, {27'd0, dec.shamt});
	endtask

	task automatic test_stall();
		logic [31:0] pc_a;
		logic [31:0] pc_b;
		pc_a = pc_next;
		pc_b = pc_next + 32'd4;
		drive_fetch(enc_r(5'd1, 5'd2, 5'd3, fn_addu));
		@(posedge clk);
		#1;
		drive_fetch(enc_r(5'd4, 5'd5, 5'd6, fn_or));
		@(posedge clk);
		#1;
		check_word("stall_first", pc_a, dec.pc);
		stall = 1'b1;
		// this one must be ignored
		drive_fetch(enc_r(5'd7, 5'd8, 5'd9, fn_xor));
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			#1;
			check_word("stall_valid", 32'd1, {31'd0, dec_valid});
			check_word("stall_hold", pc_a, dec.pc);
		end
		stall       = 1'b0;
		fetch_valid = 1'b0;
		@(posedge clk);
		#1;
		check_word("stall_release_valid", 32'd1, {31'd0, dec_valid});
		check_word("stall_release_pc", pc_b, dec.pc);
		@(posedge clk);
		#1;
		check_word("stall_ignored_fetch", 32'd0, {31'd0, dec_valid});
	endtask

	task automatic test_flush();
		flush = 1'b1;
		drive_fetch(enc_r(5'd1, 5'd2, 5'd3, fn_and));
		@(posedge clk);
		#1;
		flush       = 1'b0;
		fetch_valid = 1'b0;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk);
			#1;
			check_word("flush_dropped", 32'd0, {31'd0, dec_valid});
		end
	endtask

	initial begin
		errors       = 0;
		checks       = 0;
		lfsr_state   = 32'h0efb_60b9;
		pc_next      = 32'h0000_1000;
		rst_n        = 1'b0;
		fetch_valid  = 1'b0;
		fetch        = '0;
		stall        = 1'b0;
		flush        = 1'b0;
		flush_except = 1'b0;
		wb_en        = 1'b0;
		wb_addr      = 5'd0;
		wb_data      = 32'd0;
		for (int i = 0; i < 32; i++)
			shadow[i] = 32'd0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		test_reset();
		test_ctrl();
		test_regs();
		test_exceptions();
		test_dest();
		test_stall();
		test_flush();

		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: compile.f
hdl/mips_pkg.sv
hdl/main_decoder.sv
hdl/alu_decoder.sv
hdl/reg_file.sv
hdl/pipe_reg.sv
hdl/decode_stage.sv
hdl/decode_top.sv
tests/tb_decode.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_decode \
	-f compile.f \
	-o tb_decode_sim

./obj_dir/tb_decode_sim | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
exit 1
